// ==== sources.f ====
verilog/board_pkg.sv
verilog/reset_stretch.sv
verilog/uart_rx.sv
verilog/uart_tx.sv
verilog/cmd_bridge.sv
verilog/led_regs.sv
verilog/board_top.sv
tb/board_top_sva.sv
tb/board_top_tb.sv

// ==== Makefile ====
VERILATOR = verilator
VFLAGS    = --binary --timing --assert
TOP       = board_top_tb
FILELIST  = sources.f
OBJ_DIR   = obj_dir
LOG       = sim.log
SIM_BIN   = $(OBJ_DIR)/V$(TOP)
SOURCES   = $(shell cat $(FILELIST))

.PHONY: all compile run clean

all: run

compile: $(SIM_BIN)

$(SIM_BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)

run: compile
	./$(SIM_BIN) | tee $(LOG)
	grep -qx "Simulation passed" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// ==== tb/board_top_tb.sv ====
/* directed testbench for the board top level, acting as the uart host
   toward the command bridge and its register block */
`timescale 1ns/1ps
`default_nettype none

module board_top_tb
  import board_pkg::*;
();

  // cycles to wait for a response start bit
  localparam int rsp_timeout = 20 * clks_per_bit;

  logic                clk;
  logic                reset;
  logic [num_btns-1:0] button;
  logic                uart_rx;
  logic [num_leds-1:0] leds;
  logic                uart_tx;

  integer              seed;
  int                  errors;
  int                  checks;
  int                  tests;
  logic [num_leds-1:0] led_expect;

  board_top uut (
    .clk     (clk),
    .reset   (reset),
    .button  (button),
    .uart_rx (uart_rx),
    .leds    (leds),
    .uart_tx (uart_tx)
  );

  initial clk = 1'b0;
  always #2 clk = ~clk;

  task automatic check_value(input string name, input string what,
                             input logic [7:0] exp, input logic [7:0] act);
    checks++;
    assert (act === exp) else begin
      errors++;
      $display("FAILED %s %s: expected %h, actual %h", name, what, exp, act);
    end
  endtask

  task automatic check_true(input string name, input logic cond, input string msg);
    checks++;
    assert (cond === 1'b1) else begin
      errors++;
      $display("%s: %s", name, msg);
    end
  endtask

  // start, 8 data bits lsb first, stop
  task automatic send_byte(input logic [7:0] data);
    logic [9:0] frame;
    frame = {1'b1, data, 1'b0};
    for (int i = 0; i < 10; i++) begin
      uart_rx = frame[i];
      repeat (clks_per_bit) @(negedge clk);
    end
  endtask

  task automatic recv_byte(input string name, output logic [7:0] data);
    int wait_cyc;
    data = 8'hxx;
    wait_cyc = 0;
    while (uart_tx !== 1'b0 && wait_cyc < rsp_timeout) begin
      @(negedge clk);
      wait_cyc++;
    end
    check_true(name, uart_tx === 1'b0, "timeout, no start bit on uart_tx");
    if (uart_tx === 1'b0) begin
      // move to mid-bit
      repeat (clks_per_bit / 2) @(negedge clk);
      check_true(name, !uart_tx, "start bit on uart_tx did not hold low");
      for (int i = 0; i < 8; i++) begin
        repeat (clks_per_bit) @(negedge clk);
        data[i] = uart_tx;
      end
      repeat (clks_per_bit) @(negedge clk);
      check_true(name, uart_tx, "stop bit on uart_tx read low");
    end
  endtask

  task automatic write_reg(input string name, input logic [7:0] addr,
                           input logic [7:0] data, input logic [7:0] exp_rsp);
    logic [7:0] rsp;
    send_byte(op_write);
    send_byte(addr);
    send_byte(data);
    recv_byte(name, rsp);
    check_value(name, "write response", exp_rsp, rsp);
  endtask

  task automatic read_reg(input string name, input logic [7:0] addr,
                          input logic [7:0] exp);
    logic [7:0] rsp;
    send_byte(op_read);
    send_byte(addr);
    recv_byte(name, rsp);
    check_value(name, "read response", exp, rsp);
  endtask

  task automatic report_test(input string name, input int err_start);
    tests++;
    $display("test %s: %s", name, (errors == err_start) ? "ok" : "errors found");
  endtask

  // response line stays high for two bit times
  task automatic check_line_idle(input string name, input string msg);
    logic idle;
    idle = 1'b1;
    for (int i = 0; i < 2 * clks_per_bit; i++) begin
      @(negedge clk);
      if (uart_tx !== 1'b1) begin
        idle = 1'b0;
      end
    end
    check_true(name, idle, msg);
  endtask

  // start bit ends inside the stretch window, the byte must be lost
  task automatic check_stretch(input string name);
    repeat (reset_stretch_len - clks_per_bit) @(negedge clk);
    // unknown opcode, would be answered by a live core
    send_byte(8'hff);
    check_value(name, "leds after the stretch", 8'h00, {3'b000, leds});
    check_line_idle(name, "byte answered during the reset stretch");
  endtask

  task automatic test_reset_stretch;
    string name;
    int    err_start;
    name = "reset_stretch";
    err_start = errors;
    check_stretch(name);
    write_reg(name, reg_led_addr, 8'h15, rsp_ack);
    check_value(name, "leds after write", 8'h15, {3'b000, leds});
    // ready low, command sent into a held core
    button[0] = 1'b0;
    send_byte(op_read);
    send_byte(reg_led_addr);
    check_value(name, "leds with ready low", 8'h00, {3'b000, leds});
    check_line_idle(name, "command answered while the core was in reset");
    button[0] = 1'b1;
    check_stretch(name);
    led_expect = '0;
    read_reg(name, reg_led_addr, 8'h00);
    report_test(name, err_start);
  endtask

  task automatic test_led_rw;
    string      name;
    int         err_start;
    logic [7:0] val;
    name = "led_rw";
    err_start = errors;
    val = 8'($random(seed));
    write_reg(name, reg_led_addr, val, rsp_ack);
    led_expect = val[num_leds-1:0];
    check_value(name, "leds", {3'b000, led_expect}, {3'b000, leds});
    read_reg(name, reg_led_addr, {3'b000, led_expect});
    report_test(name, err_start);
  endtask

  task automatic test_scratch;
    string      name;
    int         err_start;
    logic [7:0] val;
    name = "scratch";
    err_start = errors;
    for (int i = 0; i < 4; i++) begin
      val = 8'($random(seed));
      write_reg(name, reg_scratch_addr, val, rsp_ack);
      read_reg(name, reg_scratch_addr, val);
      // led register untouched
      check_value(name, "leds", {3'b000, led_expect}, {3'b000, leds});
    end
    report_test(name, err_start);
  endtask

  task automatic test_button;
    string name;
    int    err_start;
    name = "button";
    err_start = errors;
    button[1] = 1'b1;
    read_reg(name, reg_btn_addr, 8'h01);
    button[1] = 1'b0;
    read_reg(name, reg_btn_addr, 8'h00);
    // status register is read only
    write_reg(name, reg_btn_addr, 8'($random(seed)), rsp_err);
    report_test(name, err_start);
  endtask

  task automatic test_errors;
    string      name;
    int         err_start;
    logic [7:0] rsp;
    logic [7:0] val;
    name = "errors";
    err_start = errors;
    read_reg(name, 8'h10, rsp_err);
    write_reg(name, 8'h10, 8'h5a, rsp_err);
    // neither 'W' nor 'R'
    send_byte(8'h3f);
    recv_byte(name, rsp);
    check_value(name, "unknown opcode response", rsp_err, rsp);
    val = 8'($random(seed));
    write_reg(name, reg_scratch_addr, val, rsp_ack);
    read_reg(name, reg_scratch_addr, val);
    report_test(name, err_start);
  endtask

  initial begin
    seed = 32'hd236_e003;
    errors = 0;
    checks = 0;
    tests = 0;
    led_expect = '0;
    reset = 1'b1;
    button = 2'b01;
    uart_rx = 1'b1;
    repeat (10) @(negedge clk);
    reset = 1'b0;

    test_reset_stretch();
    test_led_rw();
    test_scratch();
    test_button();
    test_errors();

    $display("%0d tests, %0d checks, %0d errors", tests, checks, errors);
    if (errors == 0) begin
      $display("Simulation passed");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== tb/board_top_sva.sv ====
/* axi4-lite and transmit handshake checks for the command bridge,
   bound into every cmd_bridge instance */
`timescale 1ns/1ps
`default_nettype none

module board_top_sva
  import board_pkg::*;
(
  input logic                  clk,
  input logic                  reset,
  input logic [axi_addr_w-1:0] awaddr,
  input logic                  awvalid,
  input logic                  awready,
  input logic [axi_data_w-1:0] wdata,
  input logic                  wvalid,
  input logic                  wready,
  input logic                  bvalid,
  input logic                  bready,
  input logic [axi_addr_w-1:0] araddr,
  input logic                  arvalid,
  input logic                  arready,
  input logic                  rvalid,
  input logic                  rready,
  input logic                  tx_start,
  input logic                  tx_busy
);

  logic pending;

  // request accepted, response not yet taken
  always_ff @(posedge clk) begin
    if (reset) begin
      pending <= 1'b0;
    end else if ((awvalid && awready) || (arvalid && arready)) begin
      pending <= 1'b1;
    end else if ((bvalid && bready) || (rvalid && rready)) begin
      pending <= 1'b0;
    end
  end

  // valid and payload held until the handshake
  aw_stable: assert property (@(posedge clk) disable iff (reset)
    awvalid |=> $past(awready) || (awvalid && $stable(awaddr)))
    else $error("aw valid or address changed before the handshake");

  w_stable: assert property (@(posedge clk) disable iff (reset)
    wvalid |=> $past(wready) || (wvalid && $stable(wdata)))
    else $error("w valid or data changed before the handshake");

  ar_stable: assert property (@(posedge clk) disable iff (reset)
    arvalid |=> $past(arready) || (arvalid && $stable(araddr)))
    else $error("ar valid or address changed before the handshake");

  // no new request while a response is still owed
  one_outstanding: assert property (@(posedge clk) disable iff (reset)
    (awvalid && awready) || (arvalid && arready) |-> !pending)
    else $error("new request accepted while a response was pending");

  // start pulse only toward an idle transmitter
  tx_start_idle: assert property (@(posedge clk) disable iff (reset)
    tx_start |-> !tx_busy)
    else $error("tx_start pulsed while the transmitter was busy");

  // master outputs quiet on leaving reset
  quiet_after_reset: assert property (@(posedge clk)
    $fell(reset) |-> !awvalid && !wvalid && !arvalid && !tx_start)
    else $error("bridge outputs active right after reset");

endmodule

bind cmd_bridge board_top_sva u_sva (
  .clk      (clk),
  .reset    (reset),
  .awaddr   (awaddr),
  .awvalid  (awvalid),
  .awready  (awready),
  .wdata    (wdata),
  .wvalid   (wvalid),
  .wready   (wready),
  .bvalid   (bvalid),
  .bready   (bready),
  .araddr   (araddr),
  .arvalid  (arvalid),
  .arready  (arready),
  .rvalid   (rvalid),
  .rready   (rready),
  .tx_start (tx_start),
  .tx_busy  (tx_busy)
);

`default_nettype wire

// ==== verilog/board_top.sv ====
/* board top level: reset stretcher, uart pair,
   command bridge and the led register block */
`timescale 1ns/1ps
`default_nettype none

module board_top
  import board_pkg::*;
(
  input  logic                clk,
  input  logic                reset,
  input  logic [num_btns-1:0] button,
  input  logic                uart_rx,
  output logic [num_leds-1:0] leds,
  output logic                uart_tx
);

  logic                    core_reset;
  logic [7:0]              rx_data;
  logic                    rx_valid;
  logic [7:0]              tx_data;
  logic                    tx_start;
  logic                    tx_busy;
  logic [axi_addr_w-1:0]   awaddr;
  logic                    awvalid;
  logic                    awready;
  logic [axi_data_w-1:0]   wdata;
  logic [axi_data_w/8-1:0] wstrb;
  logic                    wvalid;
  logic                    wready;
  logic [1:0]              bresp;
  logic                    bvalid;
  logic                    bready;
  logic [axi_addr_w-1:0]   araddr;
  logic                    arvalid;
  logic                    arready;
  logic [axi_data_w-1:0]   rdata;
  logic [1:0]              rresp;
  logic                    rvalid;
  logic                    rready;

  // button 0 doubles as the ready input
  reset_stretch u_reset_stretch (
    .clk        (clk),
    .reset      (reset),
    .ready      (button[0]),
    .core_reset (core_reset)
  );

  uart_rx u_uart_rx (
    .clk      (clk),
    .reset    (core_reset),
    .rx       (uart_rx),
    .rx_data  (rx_data),
    .rx_valid (rx_valid)
  );

  uart_tx u_uart_tx (
    .clk      (clk),
    .reset    (core_reset),
    .tx_data  (tx_data),
    .tx_start (tx_start),
    .tx       (uart_tx),
    .tx_busy  (tx_busy)
  );

  // axi master
  cmd_bridge u_cmd_bridge (
    .clk      (clk),
    .reset    (core_reset),
    .rx_data  (rx_data),
    .rx_valid (rx_valid),
    .tx_busy  (tx_busy),
    .tx_data  (tx_data),
    .tx_start (tx_start),
    .awaddr   (awaddr),
    .awvalid  (awvalid),
    .awready  (awready),
    .wdata    (wdata),
    .wstrb    (wstrb),
    .wvalid   (wvalid),
    .wready   (wready),
    .bresp    (bresp),
    .bvalid   (bvalid),
    .bready   (bready),
    .araddr   (araddr),
    .arvalid  (arvalid),
    .arready  (arready),
    .rdata    (rdata),
    .rresp    (rresp),
    .rvalid   (rvalid),
    .rready   (rready)
  );

  // axi slave, button 1 goes to the status register
  led_regs u_led_regs (
    .clk       (clk),
    .reset     (core_reset),
    .button_in (button[1]),
    .leds      (leds),
    .awaddr    (awaddr),
    .awvalid   (awvalid),
    .awready   (awready),
    .wdata     (wdata),
    .wstrb     (wstrb),
    .wvalid    (wvalid),
    .wready    (wready),
    .bresp     (bresp),
    .bvalid    (bvalid),
    .bready    (bready),
    .araddr    (araddr),
    .arvalid   (arvalid),
    .arready   (arready),
    .rdata     (rdata),
    .rresp     (rresp),
    .rvalid    (rvalid),
    .rready    (rready)
  );

endmodule

`default_nettype wire

// ==== verilog/led_regs.sv ====
/* axi4-lite register block: led, button status and scratch
   registers, slverr on read-only or unmapped addresses */
`timescale 1ns/1ps
`default_nettype none

module led_regs
  import board_pkg::*;
(
  input  logic                    clk,
  input  logic                    reset,
  input  logic                    button_in,
  output logic [num_leds-1:0]     leds,
  input  logic [axi_addr_w-1:0]   awaddr,
  input  logic                    awvalid,
  output logic                    awready,
  input  logic [axi_data_w-1:0]   wdata,
  input  logic [axi_data_w/8-1:0] wstrb,
  input  logic                    wvalid,
  output logic                    wready,
  output logic [1:0]              bresp,
  output logic                    bvalid,
  input  logic                    bready,
  input  logic [axi_addr_w-1:0]   araddr,
  input  logic                    arvalid,
  output logic                    arready,
  output logic [axi_data_w-1:0]   rdata,
  output logic [1:0]              rresp,
  output logic                    rvalid,
  input  logic                    rready
);

  logic [num_leds-1:0] led_reg;
  logic [7:0]          scratch;
  logic                btn_meta;
  logic                btn_sync;
  logic                wr_fire;
  logic                rd_fire;

  // address and data accepted together, one write in flight
  assign awready = !bvalid && awvalid && wvalid;
  assign wready  = awready;
  assign wr_fire = awready;
  // one read in flight
  assign arready = !rvalid;
  assign rd_fire = arvalid && arready;

  always_ff @(posedge clk) begin
    btn_meta <= button_in;
    btn_sync <= btn_meta;
  end

  // write channel
  always_ff @(posedge clk) begin
    if (reset) begin
      led_reg <= '0;
      bvalid  <= 1'b0;
    end else if (wr_fire) begin
      bvalid <= 1'b1;
      bresp  <= resp_okay;
      case (awaddr)
        reg_led_addr: begin
          if (wstrb[0]) led_reg <= wdata[num_leds-1:0];
        end
        reg_scratch_addr: begin
          if (wstrb[0]) scratch <= wdata[7:0];
        end
        // button status is read only
        default: bresp <= resp_slverr;
      endcase
    end else if (bready) begin
      bvalid <= 1'b0;
    end
  end

  // read channel
  always_ff @(posedge clk) begin
    if (reset) begin
      rvalid <= 1'b0;
    end else if (rd_fire) begin
      rvalid <= 1'b1;
      rresp  <= resp_okay;
      case (araddr)
        reg_led_addr:     rdata <= {{(axi_data_w - num_leds){1'b0}}, led_reg};
        reg_btn_addr:     rdata <= {{(axi_data_w - 1){1'b0}}, btn_sync};
        reg_scratch_addr: rdata <= {{(axi_data_w - 8){1'b0}}, scratch};
        default: begin
          rdata <= '0;
          rresp <= resp_slverr;
        end
      endcase
    end else if (rready) begin
      rvalid <= 1'b0;
    end
  end

  assign leds = led_reg;

endmodule

`default_nettype wire

// ==== verilog/cmd_bridge.sv ====
/* uart command bridge: opcode, address and data bytes in,
   one axi4-lite transaction per command, one response byte out */
`timescale 1ns/1ps
`default_nettype none

module cmd_bridge
  import board_pkg::*;
(
  input  logic                    clk,
  input  logic                    reset,
  input  logic [7:0]              rx_data,
  input  logic                    rx_valid,
  input  logic                    tx_busy,
  output logic [7:0]              tx_data,
  output logic                    tx_start,
  output logic [axi_addr_w-1:0]   awaddr,
  output logic                    awvalid,
  input  logic                    awready,
  output logic [axi_data_w-1:0]   wdata,
  output logic [axi_data_w/8-1:0] wstrb,
  output logic                    wvalid,
  input  logic                    wready,
  input  logic [1:0]              bresp,
  input  logic                    bvalid,
  output logic                    bready,
  output logic [axi_addr_w-1:0]   araddr,
  output logic                    arvalid,
  input  logic                    arready,
  input  logic [axi_data_w-1:0]   rdata,
  input  logic [1:0]              rresp,
  input  logic                    rvalid,
  output logic                    rready
);

  bridge_state_t           state;
  cmd_opcode_t             opcode;
  logic [axi_addr_w-1:0]   addr;
  logic [7:0]              data_byte;
  logic [7:0]              rsp;
  logic                    aw_done;
  logic                    w_done;

  // channel finished, earlier or in this cycle
  assign aw_done = !awvalid || awready;
  assign w_done  = !wvalid || wready;

  always_ff @(posedge clk) begin
    if (reset) begin
      state    <= st_idle;
      awvalid  <= 1'b0;
      wvalid   <= 1'b0;
      arvalid  <= 1'b0;
      tx_start <= 1'b0;
    end else begin
      tx_start <= 1'b0;
      case (state)
        st_idle: begin
          if (rx_valid) begin
            opcode <= cmd_opcode_t'(rx_data);
            if (rx_data == op_write || rx_data == op_read) begin
              state <= st_addr;
            end else begin
              // unknown opcode, answer right away
              rsp   <= rsp_err;
              state <= st_send;
            end
          end
        end
        st_addr: begin
          if (rx_valid) begin
            addr <= rx_data;
            if (opcode == op_write) begin
              state <= st_data;
            end else begin
              arvalid <= 1'b1;
              state   <= st_rd_req;
            end
          end
        end
        st_data: begin
          if (rx_valid) begin
            data_byte <= rx_data;
            awvalid   <= 1'b1;
            wvalid    <= 1'b1;
            state     <= st_wr_req;
          end
        end
        st_wr_req: begin
          // each valid drops on its own handshake
          if (awready) begin
            awvalid <= 1'b0;
          end
          if (wready) begin
            wvalid <= 1'b0;
          end
          if (aw_done && w_done) begin
            state <= st_wr_resp;
          end
        end
        st_wr_resp: begin
          if (bvalid) begin
            rsp   <= (bresp == resp_okay) ? rsp_ack : rsp_err;
            state <= st_send;
          end
        end
        st_rd_req: begin
          if (arready) begin
            arvalid <= 1'b0;
            state   <= st_rd_resp;
          end
        end
        st_rd_resp: begin
          if (rvalid) begin
            rsp   <= (rresp == resp_okay) ? rdata[7:0] : rsp_err;
            state <= st_send;
          end
        end
        st_send: begin
          if (!tx_busy) begin
            tx_start <= 1'b1;
            state    <= st_wait_tx;
          end
        end
        st_wait_tx: begin
          // busy rises one cycle after the start pulse
          if (!tx_start && !tx_busy) begin
            state <= st_idle;
          end
        end
        default: state <= st_idle;
      endcase
    end
  end

  assign tx_data = rsp;

  // same address for both directions
  assign awaddr = addr;
  assign araddr = addr;
  assign wdata  = {{(axi_data_w - 8){1'b0}}, data_byte};
  // only the low byte lane carries data
  assign wstrb  = {{(axi_data_w / 8 - 1){1'b0}}, 1'b1};

  // always ready in the response states
  assign bready = (state == st_wr_resp);
  assign rready = (state == st_rd_resp);

endmodule

`default_nettype wire

// ==== verilog/uart_tx.sv ====
/* uart transmitter, 8n1, lsb first
   tx_busy covers the whole frame up to the end of the stop bit */
`timescale 1ns/1ps
`default_nettype none

module uart_tx
  import board_pkg::*;
(
  input  logic       clk,
  input  logic       reset,
  input  logic [7:0] tx_data,
  input  logic       tx_start,
  output logic       tx,
  output logic       tx_busy
);

  logic [9:0]       frame;
  logic [3:0]       bit_idx;
  logic [cyc_w-1:0] cyc_cnt;

  always_ff @(posedge clk) begin
    if (reset) begin
      tx_busy <= 1'b0;
      bit_idx <= 4'd0;
      cyc_cnt <= '0;
    end else if (!tx_busy) begin
      if (tx_start) begin
        // stop, data, start
        frame   <= {1'b1, tx_data, 1'b0};
        tx_busy <= 1'b1;
        bit_idx <= 4'd0;
        cyc_cnt <= cyc_w'(clks_per_bit - 1);
      end
    end else if (cyc_cnt != '0) begin
      cyc_cnt <= cyc_cnt - 1'b1;
    end else if (bit_idx == 4'd9) begin
      // stop bit done
      tx_busy <= 1'b0;
    end else begin
      frame   <= {1'b1, frame[9:1]};
      bit_idx <= bit_idx + 4'd1;
      cyc_cnt <= cyc_w'(clks_per_bit - 1);
    end
  end

  // line idles high
  assign tx = tx_busy ? frame[0] : 1'b1;

endmodule

`default_nettype wire

// ==== verilog/uart_rx.sv ====
/* uart receiver, 8n1, lsb first
   centers on the start bit and pulses rx_valid at mid stop bit */
`timescale 1ns/1ps
`default_nettype none

module uart_rx
  import board_pkg::*;
(
  input  logic       clk,
  input  logic       reset,
  input  logic       rx,
  output logic [7:0] rx_data,
  output logic       rx_valid
);

  logic             rx_meta;
  logic             rx_sync;
  logic             busy;
  logic [3:0]       bit_idx;
  logic [cyc_w-1:0] cyc_cnt;
  logic [7:0]       shreg;

  // two flop synchronizer, idles high
  always_ff @(posedge clk) begin
    if (reset) begin
      rx_meta <= 1'b1;
      rx_sync <= 1'b1;
    end else begin
      rx_meta <= rx;
      rx_sync <= rx_meta;
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      busy     <= 1'b0;
      bit_idx  <= 4'd0;
      cyc_cnt  <= '0;
      rx_valid <= 1'b0;
    end else begin
      rx_valid <= 1'b0;
      if (!busy) begin
        // falling edge, wait half a bit
        if (!rx_sync) begin
          busy    <= 1'b1;
          bit_idx <= 4'd0;
          cyc_cnt <= cyc_w'(clks_per_bit / 2 - 1);
        end
      end else if (cyc_cnt != '0) begin
        cyc_cnt <= cyc_cnt - 1'b1;
      end else begin
        // mid-bit sample point
        cyc_cnt <= cyc_w'(clks_per_bit - 1);
        bit_idx <= bit_idx + 4'd1;
        if (bit_idx == 4'd0) begin
          // glitch, not a real start bit
          if (rx_sync) begin
            busy <= 1'b0;
          end
        end else if (bit_idx == 4'd9) begin
          busy <= 1'b0;
          // framing error drops the byte
          rx_valid <= rx_sync;
        end else begin
          shreg <= {rx_sync, shreg[7:1]};
        end
      end
    end
  end

  // shift reg holds still until the next start bit
  assign rx_data = shreg;

endmodule

`default_nettype wire

// ==== verilog/reset_stretch.sv ====
/* reset stretcher: keeps the core in reset until ready
   has been high for a fixed number of cycles */
`timescale 1ns/1ps
`default_nettype none

module reset_stretch
  import board_pkg::*;
(
  input  logic clk,
  input  logic reset,
  input  logic ready,
  output logic core_reset
);

  logic [reset_stretch_len-1:0] stretch;

  always_ff @(posedge clk) begin
    if (reset || !ready) begin
      // reload, ready dropped or board reset
      stretch    <= '1;
      core_reset <= 1'b1;
    end else begin
      // zeros walk down the chain
      stretch    <= {1'b0, stretch[reset_stretch_len-1:1]};
      // last stage of the chain
      core_reset <= stretch[0];
    end
  end

endmodule

`default_nettype wire

// ==== verilog/board_pkg.sv ====
/* board package: sizes, uart timing, register map,
   axi response codes, command opcodes and bridge states */
`default_nettype none

package board_pkg;

  // board resources
  localparam int num_leds          = 5;
  localparam int num_btns          = 2;
  localparam int reset_stretch_len = 16;

  // uart bit timing, short for simulation
  localparam int clks_per_bit = 8;
  localparam int cyc_w        = $clog2(clks_per_bit);

  // axi4-lite link
  localparam int axi_addr_w = 8;
  localparam int axi_data_w = 32;

  // register map
  localparam logic [7:0] reg_led_addr     = 8'h00;
  localparam logic [7:0] reg_btn_addr     = 8'h04;
  localparam logic [7:0] reg_scratch_addr = 8'h08;

  localparam logic [1:0] resp_okay   = 2'b00;
  localparam logic [1:0] resp_slverr = 2'b10;

  // response bytes, 'K' and 'E'
  localparam logic [7:0] rsp_ack = 8'h4b;
  localparam logic [7:0] rsp_err = 8'h45;

  // host opcodes, 'W' and 'R'
  typedef enum logic [7:0] {
    op_write = 8'h57,
    op_read  = 8'h52
  } cmd_opcode_t;

  typedef enum logic [3:0] {
    st_idle,
    st_addr,
    st_data,
    st_wr_req,
    st_wr_resp,
    st_rd_req,
    st_rd_resp,
    st_send,
    st_wait_tx
  } bridge_state_t;

endpackage

`default_nettype wire
